// ==== logic/bus_pkg.sv ====
// Host bus definitions
// Widths and packed request/response types of the single-word bus.
// A request is a one-cycle strobe, a response a one-cycle valid pulse.

`default_nettype none

package bus_pkg;

  // ----------------------------------------------------------
  // Widths
  // ----------------------------------------------------------
  localparam int unsigned AddrWidth    = 32;
  localparam int unsigned DataWidth    = 32;
  localparam int unsigned StrbWidth    = DataWidth / 8;
  // Address bits below the word index
  localparam int unsigned ByteOffWidth = $clog2(StrbWidth);

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;

  // ----------------------------------------------------------
  // Bus payloads
  // ----------------------------------------------------------
  typedef struct packed {
    logic  req;
    logic  we;
    addr_t addr;
    strb_t be;
    data_t wdata;
  } bus_req_t;

  typedef struct packed {
    logic  rvalid;
    logic  err;
    data_t rdata;
  } bus_rsp_t;

endpackage

`default_nettype wire

// ==== logic/soc_cfg_pkg.sv ====
// SoC fabric configuration
// Address map of the boot ROM and data RAM, decoded target regions,
// memory sizes and the debug hold-off window after power-on reset.

`default_nettype none

package soc_cfg_pkg;

  // ----------------------------------------------------------
  // Address map
  // ----------------------------------------------------------
  localparam int unsigned RomBase   = 32'h0001_0000;
  localparam int unsigned RomLength = 64;
  localparam int unsigned RamBase   = 32'h8000_0000;
  localparam int unsigned RamLength = 4096;

  // Word counts, four bytes per word
  localparam int unsigned RomWords    = RomLength / 4;
  localparam int unsigned RamWords    = RamLength / 4;
  localparam int unsigned RomIdxWidth = $clog2(RomWords);
  localparam int unsigned RamIdxWidth = $clog2(RamWords);

  // Boot image, also read by the testbench
  localparam string RomInitFile = "logic/boot_rom.hex";

  // ----------------------------------------------------------
  // Debug
  // ----------------------------------------------------------
  // Cycles after power-on reset during which debug requests are blocked
  localparam int unsigned DebugHoldoffCycles = 20;
  localparam int unsigned DebugCntWidth      = $clog2(DebugHoldoffCycles + 1);

  // Decoded target of a request
  typedef enum logic [1:0] {
    REGION_ROM,
    REGION_RAM,
    REGION_NONE
  } region_e;

endpackage

`default_nettype wire

// ==== logic/debug_ctrl.sv ====
// Debug and reset control
// Merges power-on reset with the non-debug reset into a synchronized
// core reset, and gates the raw debug request with the debug enable
// and a hold-off window that follows power-on reset.

`timescale 1ns/100ps
`default_nettype none

module debug_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ndmreset_i,
  input  logic dbg_req_i,
  input  logic dbg_enable_i,
  output logic dbg_req_o,
  output logic core_rst_no
);

  import soc_cfg_pkg::*;

  logic                     sys_rst_n;
  logic [1:0]               rst_sync_q;
  logic [DebugCntWidth-1:0] holdoff_q;

  // ----------------------------------------------------------
  // Core reset synchronizer
  // ----------------------------------------------------------
  // Asserts at once, releases two edges after both sources clear
  assign sys_rst_n = rst_ni & ~ndmreset_i;

  always_ff @(posedge clk_i or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      rst_sync_q <= 2'b00;
    end else begin
      rst_sync_q <= {rst_sync_q[0], 1'b1};
    end
  end

  assign core_rst_no = rst_sync_q[1];

  // ----------------------------------------------------------
  // Debug request hold-off
  // ----------------------------------------------------------
  // Only power-on reset reloads the window, ndmreset leaves it alone
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      holdoff_q <= DebugCntWidth'(DebugHoldoffCycles);
    end else if (holdoff_q != '0) begin
      holdoff_q <= holdoff_q - 1'b1;
    end
  end

  // Masked while counting down or while debug is disabled
  assign dbg_req_o = (holdoff_q == '0) & dbg_enable_i & dbg_req_i;

endmodule

`default_nettype wire

// ==== logic/addr_decode.sv ====
// Address decoder
// Maps each host request onto the boot ROM, the data RAM or no region,
// forwards it with the strobe set only towards the hit memory, and
// reports the region and write flag of every accepted request.

`timescale 1ns/100ps
`default_nettype none

module addr_decode (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  bus_pkg::bus_req_t    req_i,
  output bus_pkg::bus_req_t    rom_req_o,
  output bus_pkg::bus_req_t    ram_req_o,
  output soc_cfg_pkg::region_e region_o,
  output logic                 acc_valid_o,
  output logic                 acc_we_o
);

  import bus_pkg::*;
  import soc_cfg_pkg::*;

  addr_t addr;
  logic  fwd_en_q;
  logic  acc;

  // Forwarding opens one cycle after core reset is released
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fwd_en_q <= 1'b0;
    end else begin
      fwd_en_q <= 1'b1;
    end
  end

  assign addr = req_i.addr;
  assign acc  = req_i.req & fwd_en_q;

  // Region windows, half-open ranges
  always_comb begin
    if (addr >= RomBase && addr < RomBase + RomLength) begin
      region_o = REGION_ROM;
    end else if (addr >= RamBase && addr < RamBase + RamLength) begin
      region_o = REGION_RAM;
    end else begin
      region_o = REGION_NONE;
    end
  end

  // Payload goes to both memories, only the hit one sees the strobe
  always_comb begin
    rom_req_o     = req_i;
    ram_req_o     = req_i;
    rom_req_o.req = acc && (region_o == REGION_ROM);
    ram_req_o.req = acc && (region_o == REGION_RAM);
  end

  assign acc_valid_o = acc;
  assign acc_we_o    = req_i.we;

endmodule

`default_nettype wire

// ==== logic/boot_rom.sv ====
// Boot ROM
// Word memory preloaded with the boot image. A read strobe registers
// the addressed word; write strobes are ignored.

`timescale 1ns/100ps
`default_nettype none

module boot_rom (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  bus_pkg::bus_req_t req_i,
  output bus_pkg::data_t    rdata_o
);

  import bus_pkg::*;
  import soc_cfg_pkg::*;

  data_t                  mem [RomWords];
  logic [RomIdxWidth-1:0] idx;

  initial begin
    $readmemh(RomInitFile, mem);
  end

  // Word index, byte offset dropped
  assign idx = req_i.addr[ByteOffWidth +: RomIdxWidth];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (req_i.req && !req_i.we) begin
      rdata_o <= mem[idx];
    end
  end

endmodule

`default_nettype wire

// ==== logic/data_ram.sv ====
// Data RAM
// Word memory with byte-enable writes and a registered read port.
// Contents survive core reset; only the read register is cleared.

`timescale 1ns/100ps
`default_nettype none

module data_ram (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  bus_pkg::bus_req_t req_i,
  output bus_pkg::data_t    rdata_o
);

  import bus_pkg::*;
  import soc_cfg_pkg::*;

  data_t                  mem [RamWords];
  logic [RamIdxWidth-1:0] idx;

  assign idx = req_i.addr[ByteOffWidth +: RamIdxWidth];

  // ----------------------------------------------------------
  // Write port
  // ----------------------------------------------------------
  // Only the enabled byte lanes change
  always_ff @(posedge clk_i) begin
    if (req_i.req && req_i.we) begin
      for (int b = 0; b < StrbWidth; b++) begin
        if (req_i.be[b]) begin
          mem[idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
        end
      end
    end
  end

  // ----------------------------------------------------------
  // Read port
  // ----------------------------------------------------------
  // A read one cycle after a write sees the updated word
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (req_i.req && !req_i.we) begin
      rdata_o <= mem[idx];
    end
  end

endmodule

`default_nettype wire

// ==== logic/resp_mux.sv ====
// Response builder
// Remembers each accepted request for one cycle and forms the bus
// response: read data of the recorded memory, zero for writes, and
// an error with zero data for unmapped addresses.

`timescale 1ns/100ps
`default_nettype none

module resp_mux (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 acc_valid_i,
  input  logic                 acc_we_i,
  input  soc_cfg_pkg::region_e region_i,
  input  bus_pkg::data_t       rom_rdata_i,
  input  bus_pkg::data_t       ram_rdata_i,
  output bus_pkg::bus_rsp_t    rsp_o
);

  import bus_pkg::*;
  import soc_cfg_pkg::*;

  logic    valid_q;
  logic    we_q;
  region_e region_q;
  data_t   rd_sel;

  // One entry per cycle, the memories keep the matching data
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= 1'b0;
      we_q     <= 1'b0;
      region_q <= REGION_NONE;
    end else begin
      valid_q  <= acc_valid_i;
      we_q     <= acc_we_i;
      region_q <= region_i;
    end
  end

  always_comb begin
    case (region_q)
      REGION_ROM: rd_sel = rom_rdata_i;
      REGION_RAM: rd_sel = ram_rdata_i;
      default:    rd_sel = '0;
    endcase
  end

  always_comb begin
    rsp_o        = '0;
    rsp_o.rvalid = valid_q;
    rsp_o.err    = valid_q && (region_q == REGION_NONE);
    // Writes and unmapped accesses return zero data
    if (valid_q && !we_q) begin
      rsp_o.rdata = rd_sel;
    end
  end

endmodule

`default_nettype wire

// ==== logic/soc_fabric_top.sv ====
// SoC fabric top level
// Memory-mapped region around the core: address decode, boot ROM,
// data RAM and response path, plus the debug request gating and the
// core reset that merges power-on reset with ndmreset.

`timescale 1ns/100ps
`default_nettype none

module soc_fabric_top (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              ndmreset_i,
  input  logic              dbg_req_i,
  input  logic              dbg_enable_i,
  input  bus_pkg::bus_req_t bus_req_i,
  output logic              dbg_req_o,
  output logic              core_rst_no,
  output bus_pkg::bus_rsp_t bus_rsp_o
);

  import bus_pkg::*;
  import soc_cfg_pkg::*;

  bus_req_t rom_req;
  bus_req_t ram_req;
  region_e  acc_region;
  logic     acc_valid;
  logic     acc_we;
  data_t    rom_rdata;
  data_t    ram_rdata;

  // ----------------------------------------------------------
  // Reset and debug
  // ----------------------------------------------------------
  debug_ctrl i_debug_ctrl (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .ndmreset_i   ( ndmreset_i   ),
    .dbg_req_i    ( dbg_req_i    ),
    .dbg_enable_i ( dbg_enable_i ),
    .dbg_req_o    ( dbg_req_o    ),
    .core_rst_no  ( core_rst_no  )
  );

  // ----------------------------------------------------------
  // Bus side, all on the core reset
  // ----------------------------------------------------------
  addr_decode i_addr_decode (
    .clk_i       ( clk_i       ),
    .rst_ni      ( core_rst_no ),
    .req_i       ( bus_req_i   ),
    .rom_req_o   ( rom_req     ),
    .ram_req_o   ( ram_req     ),
    .region_o    ( acc_region  ),
    .acc_valid_o ( acc_valid   ),
    .acc_we_o    ( acc_we      )
  );

  boot_rom i_boot_rom (
    .clk_i   ( clk_i       ),
    .rst_ni  ( core_rst_no ),
    .req_i   ( rom_req     ),
    .rdata_o ( rom_rdata   )
  );

  data_ram i_data_ram (
    .clk_i   ( clk_i       ),
    .rst_ni  ( core_rst_no ),
    .req_i   ( ram_req     ),
    .rdata_o ( ram_rdata   )
  );

  resp_mux i_resp_mux (
    .clk_i       ( clk_i       ),
    .rst_ni      ( core_rst_no ),
    .acc_valid_i ( acc_valid   ),
    .acc_we_i    ( acc_we      ),
    .region_i    ( acc_region  ),
    .rom_rdata_i ( rom_rdata   ),
    .ram_rdata_i ( ram_rdata   ),
    .rsp_o       ( bus_rsp_o   )
  );

endmodule

`default_nettype wire

// ==== bench/tb_soc_fabric.sv ====
// Testbench for the SoC fabric
// Directed tests of reset, boot ROM and data RAM access, pipelined mixed
// traffic, debug request hold-off and ndmreset, checked against models
// of the ROM image and the RAM contents.

`timescale 1ns/100ps
`default_nettype none

module tb_soc_fabric;

  import bus_pkg::*;
  import soc_cfg_pkg::*;

  // Cycle budgets of the six tests plus margin
  localparam int unsigned WatchdogCycles = 100 + 200 + 1000 + 200 + 500 + 300 + 700;

  logic     clk_i        = 1'b0;
  logic     rst_ni       = 1'b0;
  logic     ndmreset_i   = 1'b0;
  logic     dbg_req_i    = 1'b0;
  logic     dbg_enable_i = 1'b0;
  bus_req_t bus_req_i    = '0;
  logic     dbg_req_o;
  logic     core_rst_no;
  bus_rsp_t bus_rsp_o;

  data_t    rom_model [RomWords];
  data_t    ram_model [RamWords];
  integer   seed         = 32'hb0d4;
  int       err_cnt      = 0;
  int       tests_run    = 0;
  int       tests_failed = 0;
  // Expected response to the request driven one cycle earlier
  logic     pend_valid   = 1'b0;
  logic     pend_err     = 1'b0;
  data_t    pend_rdata   = '0;

  soc_fabric_top UUT (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .ndmreset_i   ( ndmreset_i   ),
    .dbg_req_i    ( dbg_req_i    ),
    .dbg_enable_i ( dbg_enable_i ),
    .bus_req_i    ( bus_req_i    ),
    .dbg_req_o    ( dbg_req_o    ),
    .core_rst_no  ( core_rst_no  ),
    .bus_rsp_o    ( bus_rsp_o    )
  );

  always #50 clk_i = ~clk_i;

  initial begin
    repeat (WatchdogCycles) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, tests did not complete", WatchdogCycles);
    $display("*** TEST FAILED ***");
    $finish;
  end

  // ----------------------------------------------------------
  // Models and helpers
  // ----------------------------------------------------------
  function automatic data_t merge_bytes(input data_t old, input data_t wdata, input strb_t be);
    data_t res;
    res = old;
    for (int b = 0; b < StrbWidth; b++) begin
      if (be[b]) begin
        res[b*8 +: 8] = wdata[b*8 +: 8];
      end
    end
    return res;
  endfunction

  function automatic region_e region_of(input addr_t addr);
    region_e tgt;
    tgt = REGION_NONE;
    if (addr >= RomBase && addr < RomBase + RomLength) begin
      tgt = REGION_ROM;
    end else if (addr >= RamBase && addr < RamBase + RamLength) begin
      tgt = REGION_RAM;
    end
    return tgt;
  endfunction

  // Low address bits are random since the bus ignores them
  function automatic addr_t ram_addr(input int unsigned idx);
    return addr_t'(RamBase + idx * 4) | addr_t'($unsigned($random(seed)) % 4);
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Error: %s is %h, expected %h at %0t", name, got, exp, $time);
      err_cnt++;
    end
  endtask

  // Checks the response due now, then drives the next request
  task automatic bus_cycle(input bus_req_t req, input logic exp_err, input data_t exp_rdata);
    @(negedge clk_i);
    check_value("bus_rsp_o.rvalid", bus_rsp_o.rvalid, pend_valid);
    if (pend_valid) begin
      check_value("bus_rsp_o.err", bus_rsp_o.err, pend_err);
      check_value("bus_rsp_o.rdata", bus_rsp_o.rdata, pend_rdata);
    end
    bus_req_i  = req;
    pend_valid = req.req;
    pend_err   = exp_err;
    pend_rdata = exp_rdata;
  endtask

  task automatic idle_cycle;
    bus_cycle('0, 1'b0, '0);
  endtask

  task automatic access(input logic we, input addr_t addr, input strb_t be, input data_t wdata);
    bus_req_t    req;
    region_e     tgt;
    int unsigned idx;
    data_t       rdata;
    req       = '0;
    req.req   = 1'b1;
    req.we    = we;
    req.addr  = addr;
    req.be    = be;
    req.wdata = wdata;
    tgt       = region_of(addr);
    rdata     = '0;
    if (tgt == REGION_ROM && !we) begin
      rdata = rom_model[(addr - RomBase) >> 2];
    end else if (tgt == REGION_RAM) begin
      idx = (addr - RamBase) >> 2;
      if (we) begin
        ram_model[idx] = merge_bytes(ram_model[idx], wdata, be);
      end else begin
        rdata = ram_model[idx];
      end
    end
    bus_cycle(req, tgt == REGION_NONE, rdata);
  endtask

  task automatic power_on_reset;
    @(negedge clk_i);
    rst_ni     = 1'b0;
    pend_valid = 1'b0;
    repeat (8) begin
      @(negedge clk_i);
      check_value("core_rst_no", core_rst_no, 0);
      check_value("bus_rsp_o.rvalid", bus_rsp_o.rvalid, 0);
      check_value("dbg_req_o", dbg_req_o, 0);
    end
    rst_ni = 1'b1;
  endtask

  task automatic wait_core_release;
    int edges;
    edges = 0;
    while (core_rst_no !== 1'b1 && edges < 3) begin
      @(negedge clk_i);
      edges++;
    end
    assert (core_rst_no === 1'b1 && edges <= 2) else begin
      $display("core_rst_no did not rise by the second edge after reset release");
      err_cnt++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (err_cnt != errs_before) begin
      tests_failed++;
    end
    $display("%-20s %s", name, (err_cnt == errs_before) ? "ok" : "failed");
  endtask

  // ----------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------
  task automatic check_after_reset;
    int errs_before;
    errs_before  = err_cnt;
    dbg_req_i    = 1'b1;
    dbg_enable_i = 1'b1;
    power_on_reset();
    wait_core_release();
    check_value("dbg_req_o", dbg_req_o, 0);
    dbg_req_i    = 1'b0;
    dbg_enable_i = 1'b0;
    repeat (3) idle_cycle();
    report_test("check_after_reset", errs_before);
  endtask

  task automatic read_all_rom;
    int errs_before;
    errs_before = err_cnt;
    // Idle cycle between reads shows rvalid lasts one cycle
    for (int i = 0; i < RomWords; i++) begin
      access(1'b0, addr_t'(RomBase + i * 4), '0, '0);
      idle_cycle();
    end
    report_test("read_all_rom", errs_before);
  endtask

  task automatic ram_write_readback;
    int unsigned words [16];
    int unsigned j;
    int          errs_before;
    errs_before = err_cnt;
    // Full words first so partial writes merge into known data
    for (int k = 0; k < 16; k++) begin
      words[k] = (k * 61 + 5) % RamWords;
      access(1'b1, ram_addr(words[k]), 4'hF, $random(seed));
    end
    for (int k = 0; k < 16; k++) begin
      j = $unsigned($random(seed)) % 16;
      access(1'b1, ram_addr(words[j]), strb_t'($random(seed)), $random(seed));
      access(1'b0, ram_addr(words[j]), '0, '0);
    end
    for (int k = 0; k < 16; k++) begin
      access(1'b0, ram_addr(words[k]), '0, '0);
      idle_cycle();
    end
    report_test("ram_write_readback", errs_before);
  endtask

  task automatic back_to_back_mix;
    int errs_before;
    errs_before = err_cnt;
    access(1'b0, addr_t'(RomBase + 12), '0, '0);
    access(1'b1, ram_addr(7), 4'hF, $random(seed));
    access(1'b0, ram_addr(7), '0, '0);
    access(1'b0, 32'h4000_0000, '0, '0);
    // ROM write is acknowledged but leaves the image alone
    access(1'b1, addr_t'(RomBase + 8), 4'hF, $random(seed));
    access(1'b1, addr_t'(RomBase + RomLength), 4'hF, $random(seed));
    access(1'b0, addr_t'(RamBase + RamLength), '0, '0);
    access(1'b0, addr_t'(RomBase + 8), '0, '0);
    access(1'b1, ram_addr(7), 4'b0101, $random(seed));
    access(1'b0, ram_addr(7), '0, '0);
    idle_cycle();
    report_test("back_to_back_mix", errs_before);
  endtask

  task automatic debug_gating;
    int errs_before;
    errs_before  = err_cnt;
    dbg_req_i    = 1'b1;
    dbg_enable_i = 1'b1;
    power_on_reset();
    for (int k = 1; k <= 19; k++) begin
      @(negedge clk_i);
      check_value("dbg_req_o", dbg_req_o, 0);
    end
    repeat (2) @(negedge clk_i);
    // Request passes by cycle 21 at the latest
    check_value("dbg_req_o", dbg_req_o, 1);
    // Output follows request AND enable once the window is over
    for (int i = 0; i < 8; i++) begin
      @(negedge clk_i);
      dbg_req_i    = i[0];
      dbg_enable_i = i[1];
      #1;
      check_value("dbg_req_o", dbg_req_o, i[0] & i[1]);
    end
    report_test("debug_gating", errs_before);
  endtask

  task automatic ndmreset_pulse;
    int errs_before;
    errs_before = err_cnt;
    access(1'b1, ram_addr(100), 4'hF, $random(seed));
    idle_cycle();
    access(1'b0, ram_addr(100), '0, '0);
    // Pulse starts before the edge that would carry the read response
    @(negedge clk_i);
    ndmreset_i = 1'b1;
    bus_req_i  = '0;
    pend_valid = 1'b0;
    #1;
    check_value("core_rst_no", core_rst_no, 0);
    check_value("bus_rsp_o.rvalid", bus_rsp_o.rvalid, 0);
    repeat (3) begin
      @(negedge clk_i);
      check_value("bus_rsp_o.rvalid", bus_rsp_o.rvalid, 0);
      check_value("dbg_req_o", dbg_req_o, 1);
    end
    ndmreset_i = 1'b0;
    wait_core_release();
    check_value("dbg_req_o", dbg_req_o, 1);
    repeat (2) idle_cycle();
    access(1'b0, ram_addr(100), '0, '0);
    idle_cycle();
    report_test("ndmreset_pulse", errs_before);
  endtask

  initial begin
    $readmemh(RomInitFile, rom_model);
    check_after_reset();
    read_all_rom();
    ram_write_readback();
    back_to_back_mix();
    debug_gating();
    ndmreset_pulse();
    $display("Tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/boot_rom.hex ====
// Boot image, one 32-bit word per line, word 0 at the ROM base address
00000297
f1402573
00000597
03c58593
10500073
ffdff06f
00100313
00629023
0002a383
00738463
fe5ff06f
0000006f
deadbeef
cafef00d
12345678
a5a5a5a5

// ==== filelist.f ====
logic/bus_pkg.sv
logic/soc_cfg_pkg.sv
logic/debug_ctrl.sv
logic/addr_decode.sv
logic/boot_rom.sv
logic/data_ram.sv
logic/resp_mux.sv
logic/soc_fabric_top.sv
bench/tb_soc_fabric.sv

// ==== Bender.yml ====
package:
  name: soc_fabric

sources:
  - logic/bus_pkg.sv
  - logic/soc_cfg_pkg.sv
  - logic/debug_ctrl.sv
  - logic/addr_decode.sv
  - logic/boot_rom.sv
  - logic/data_ram.sv
  - logic/resp_mux.sv
  - logic/soc_fabric_top.sv
  - target: simulation
    files:
      - bench/tb_soc_fabric.sv
